// File: include/load_unit_params.svh
`ifndef LOAD_UNIT_PARAMS_SVH
`define LOAD_UNIT_PARAMS_SVH

// data path width
`define LU_XLEN          64
// physical address split into cache index and tag
`define LU_ADDR_WIDTH    32
`define LU_INDEX_WIDTH   12
`define LU_TAG_WIDTH     20
// scoreboard id carried through the buffer
`define LU_TRANS_ID_BITS 3
// outstanding loads, needs at least two slots
`define LU_LDBUF_ENTRIES 4
// cache request id selects a buffer slot
`define LU_REQ_ID_BITS   2
// byte position inside a doubleword
`define LU_OFFSET_BITS   3

`endif

// File: verilog/load_unit_pkg.sv
`include "load_unit_params.svh"

package load_unit_pkg;

  // ------------------------------
  // load operations
  // ------------------------------
  // signed variants fill the upper bits with the sign of the loaded field
  // the U variants fill with zeros
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } ld_op_t;

  // ------------------------------
  // cache transfer size
  // ------------------------------
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HALF  = 2'b01,
    SIZE_WORD  = 2'b10,
    SIZE_DWORD = 2'b11
  } ld_size_t;

  // ------------------------------
  // load buffer slot
  // ------------------------------
  // what is needed to retire a response once the cache answers
  typedef struct packed {
    // scoreboard id handed back with the result
    logic [`LU_TRANS_ID_BITS-1:0] trans_id;
    // low address bits, used to realign the returned word
    logic [`LU_OFFSET_BITS-1:0]   offset;
    // selects width and extension
    ld_op_t                       op;
  } ldbuf_entry_t;

endpackage

// File: verilog/load_ctrl_fsm.sv
`timescale 1ns/100ps
`include "load_unit_params.svh"

module load_ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // issue side
  input  logic                      valid_i,
  input  logic                      buf_full_i,
  input  logic [`LU_ADDR_WIDTH-1:0] paddr_i,
  output logic                      pop_ld_o,
  // cache request handshake
  input  logic                      data_gnt_i,
  output logic                      data_req_o,
  output logic                      tag_valid_o,
  output logic                      kill_req_o,
  output logic [`LU_TAG_WIDTH-1:0]  address_tag_o,
  // tells the buffer to take a new slot
  output logic                      alloc_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_t;

  state_t                    state_d;
  state_t                    state_q;
  logic                      accept_req;
  logic                      can_issue;
  logic                      granted;
  logic [`LU_TAG_WIDTH-1:0]  tag_q;

  // a new load may start only with room in the buffer
  assign accept_req = valid_i & ~buf_full_i;

  // new requests start from idle or while the previous tag goes out
  assign can_issue = (state_q == IDLE) || (state_q == SEND_TAG);

  // index accepted by the cache in this cycle
  assign granted = data_req_o & data_gnt_i;
  assign alloc_o = granted;

  // ------------------------------
  // request control
  // ------------------------------
  always_comb begin
    state_d     = state_q;
    data_req_o  = 1'b0;
    pop_ld_o    = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;

    case (state_q)
      // keep the index up until the cache takes it
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = SEND_TAG;
        end
      end

      // tag of the load granted last cycle
      SEND_TAG: begin
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      // cancel whatever was granted in the flush cycle
      WAIT_FLUSH: begin
        kill_req_o  = 1'b1;
        tag_valid_o = 1'b1;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // back to back issue overlaps with the tag cycle
    if (can_issue && accept_req) begin
      data_req_o = 1'b1;
      if (data_gnt_i) begin
        pop_ld_o = 1'b1;
        state_d  = SEND_TAG;
      end else begin
        state_d = WAIT_GNT;
      end
    end

    // flush wins over everything else
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // tag register
  // ------------------------------
  // upper address bits captured at the grant, sent one cycle later
  always_ff @(posedge clk_i) begin
    if (granted) begin
      tag_q <= paddr_i[`LU_TAG_WIDTH+`LU_INDEX_WIDTH-1:`LU_INDEX_WIDTH];
    end
  end

  assign address_tag_o = tag_q;

endmodule

// File: verilog/load_buffer.sv
`timescale 1ns/100ps
`include "load_unit_params.svh"

module load_buffer (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // allocation at the grant
  input  logic                             alloc_i,
  input  load_unit_pkg::ldbuf_entry_t      alloc_entry_i,
  output logic [`LU_REQ_ID_BITS-1:0]       free_id_o,
  output logic                             full_o,
  // kill of the last granted request
  input  logic                             kill_i,
  // cache response
  input  logic                             rvalid_i,
  input  logic [`LU_REQ_ID_BITS-1:0]       rid_i,
  output logic                             ret_valid_o,
  output load_unit_pkg::ldbuf_entry_t      ret_entry_o
);

  typedef logic [`LU_REQ_ID_BITS-1:0] req_id_t;

  logic [`LU_LDBUF_ENTRIES-1:0] valid_d;
  logic [`LU_LDBUF_ENTRIES-1:0] valid_q;
  logic [`LU_LDBUF_ENTRIES-1:0] flushed_d;
  logic [`LU_LDBUF_ENTRIES-1:0] flushed_q;
  load_unit_pkg::ldbuf_entry_t  entries_q [`LU_LDBUF_ENTRIES];
  req_id_t                      last_id_q;
  logic                         alloc_q;
  logic                         kill_last;

  // full only on registered state
  // a response frees its slot for the next cycle
  assign full_o = &valid_q;

  // ------------------------------
  // free slot search
  // ------------------------------
  // scan from the top so the lowest free slot wins
  always_comb begin
    free_id_o = '0;
    for (int i = `LU_LDBUF_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = req_id_t'(i);
      end
    end
  end

  // kill only cancels a grant from the previous cycle
  // the cache never answers it, so the slot goes back here
  assign kill_last = kill_i & alloc_q;

  // ------------------------------
  // slot bookkeeping
  // ------------------------------
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;

    // every outstanding load is dropped on its return
    if (flush_i) begin
      flushed_d = '1;
    end

    // retire answered slot
    if (rvalid_i) begin
      valid_d[rid_i] = 1'b0;
    end

    if (kill_last) begin
      valid_d[last_id_q] = 1'b0;
    end

    // new outstanding load
    // granted in the flush cycle means it is already stale
    if (alloc_i) begin
      valid_d[free_id_o]   = 1'b1;
      flushed_d[free_id_o] = flush_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
      alloc_q   <= 1'b0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      alloc_q   <= alloc_i;
      if (alloc_i) begin
        last_id_q <= free_id_o;
      end
    end
  end

  // payload of each slot
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      entries_q[free_id_o] <= alloc_entry_i;
    end
  end

  // ------------------------------
  // retire
  // ------------------------------
  assign ret_entry_o = entries_q[rid_i];

  // drop flushed slots and the one being killed right now
  assign ret_valid_o = rvalid_i & ~flushed_q[rid_i] & ~(kill_i & (rid_i == last_id_q));

endmodule

// File: verilog/load_align.sv
`timescale 1ns/100ps
`include "load_unit_params.svh"

module load_align (
  input  logic [`LU_XLEN-1:0]        rdata_i,
  input  logic [`LU_OFFSET_BITS-1:0] offset_i,
  input  load_unit_pkg::ld_op_t      op_i,
  output logic [`LU_XLEN-1:0]        result_o
);

  logic [`LU_XLEN-1:0]        shifted_data;
  logic [`LU_XLEN/8-1:0]      sign_bits;
  logic [`LU_OFFSET_BITS-1:0] sign_offset;
  logic                       is_signed;
  logic                       sign_bit;

  // ------------------------------
  // realignment
  // ------------------------------
  // move the addressed byte down to bit 0
  assign shifted_data = rdata_i >> {offset_i, 3'b000};

  // ------------------------------
  // sign selection
  // ------------------------------
  // top bit of every byte of the raw word
  // lets the sign be picked without waiting for the shifter
  for (genvar i = 0; i < `LU_XLEN / 8; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[(i+1)*8-1];
  end

  assign is_signed = op_i inside {load_unit_pkg::LW, load_unit_pkg::LH, load_unit_pkg::LB};

  // byte that holds the msb of the loaded field
  always_comb begin
    case (op_i)
      load_unit_pkg::LW, load_unit_pkg::LWU: sign_offset = offset_i + 3'd3;
      load_unit_pkg::LH, load_unit_pkg::LHU: sign_offset = offset_i + 3'd1;
      default:                               sign_offset = offset_i;
    endcase
  end

  // zero for the unsigned variants
  assign sign_bit = is_signed & sign_bits[sign_offset];

  // ------------------------------
  // result mux
  // ------------------------------
  always_comb begin
    case (op_i)
      load_unit_pkg::LW, load_unit_pkg::LWU: begin
        result_o = {{(`LU_XLEN - 32){sign_bit}}, shifted_data[31:0]};
      end
      load_unit_pkg::LH, load_unit_pkg::LHU: begin
        result_o = {{(`LU_XLEN - 16){sign_bit}}, shifted_data[15:0]};
      end
      load_unit_pkg::LB, load_unit_pkg::LBU: begin
        result_o = {{(`LU_XLEN - 8){sign_bit}}, shifted_data[7:0]};
      end
      // full doubleword at offset zero
      default: begin
        result_o = shifted_data;
      end
    endcase
  end

endmodule

// File: verilog/load_unit.sv
`timescale 1ns/100ps
`include "load_unit_params.svh"

module load_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  // issue side
  input  logic                         valid_i,
  input  logic [`LU_ADDR_WIDTH-1:0]    paddr_i,
  input  logic [7:0]                   be_i,
  input  load_unit_pkg::ld_op_t        op_i,
  input  logic [`LU_TRANS_ID_BITS-1:0] trans_id_i,
  output logic                         pop_ld_o,
  // result side
  output logic                         valid_o,
  output logic [`LU_TRANS_ID_BITS-1:0] trans_id_o,
  output logic [`LU_XLEN-1:0]          result_o,
  // cache request
  output logic                         data_req_o,
  input  logic                         data_gnt_i,
  output logic [`LU_INDEX_WIDTH-1:0]   address_index_o,
  output logic [`LU_TAG_WIDTH-1:0]     address_tag_o,
  output logic                         tag_valid_o,
  output logic                         kill_req_o,
  output logic [7:0]                   data_be_o,
  output load_unit_pkg::ld_size_t      data_size_o,
  output logic [`LU_REQ_ID_BITS-1:0]   data_id_o,
  // cache response
  input  logic                         data_rvalid_i,
  input  logic [`LU_REQ_ID_BITS-1:0]   data_rid_i,
  input  logic [`LU_XLEN-1:0]          data_rdata_i
);

  logic                        buf_full;
  logic                        alloc;
  load_unit_pkg::ldbuf_entry_t alloc_entry;
  load_unit_pkg::ldbuf_entry_t ret_entry;

  // ------------------------------
  // request fields
  // ------------------------------
  assign alloc_entry = '{
    trans_id: trans_id_i,
    offset:   paddr_i[`LU_OFFSET_BITS-1:0],
    op:       op_i
  };

  assign address_index_o = paddr_i[`LU_INDEX_WIDTH-1:0];
  assign data_be_o       = be_i;

  // transfer size follows the op width
  always_comb begin
    case (op_i)
      load_unit_pkg::LD:                     data_size_o = load_unit_pkg::SIZE_DWORD;
      load_unit_pkg::LW, load_unit_pkg::LWU: data_size_o = load_unit_pkg::SIZE_WORD;
      load_unit_pkg::LH, load_unit_pkg::LHU: data_size_o = load_unit_pkg::SIZE_HALF;
      default:                               data_size_o = load_unit_pkg::SIZE_BYTE;
    endcase
  end

  // ------------------------------
  // blocks
  // ------------------------------
  load_ctrl_fsm u_load_ctrl_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .buf_full_i    (buf_full),
    .paddr_i       (paddr_i),
    .pop_ld_o      (pop_ld_o),
    .data_gnt_i    (data_gnt_i),
    .data_req_o    (data_req_o),
    .tag_valid_o   (tag_valid_o),
    .kill_req_o    (kill_req_o),
    .address_tag_o (address_tag_o),
    .alloc_o       (alloc)
  );

  // request id is the slot that the load will occupy
  load_buffer u_load_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .alloc_i       (alloc),
    .alloc_entry_i (alloc_entry),
    .free_id_o     (data_id_o),
    .full_o        (buf_full),
    .kill_i        (kill_req_o),
    .rvalid_i      (data_rvalid_i),
    .rid_i         (data_rid_i),
    .ret_valid_o   (valid_o),
    .ret_entry_o   (ret_entry)
  );

  assign trans_id_o = ret_entry.trans_id;

  load_align u_load_align (
    .rdata_i  (data_rdata_i),
    .offset_i (ret_entry.offset),
    .op_i     (ret_entry.op),
    .result_o (result_o)
  );

endmodule

// File: verification/tb_dcache_model.sv
`timescale 1ns/100ps
`include "load_unit_params.svh"

module tb_dcache_model (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // stops all responses while set
  input  logic                         hold_rsp_i,
  input  logic [15:0]                  rnd_i,
  // request side of the load unit
  input  logic                         req_i,
  input  logic [`LU_INDEX_WIDTH-1:0]   index_i,
  input  logic [`LU_REQ_ID_BITS-1:0]   id_i,
  input  logic                         tag_valid_i,
  input  logic                         kill_i,
  input  logic [`LU_TAG_WIDTH-1:0]     tag_i,
  output logic                         gnt_o,
  // response side
  output logic                         rvalid_o,
  output logic [`LU_REQ_ID_BITS-1:0]   rid_o,
  output logic [`LU_XLEN-1:0]          rdata_o,
  // ids queued and not answered yet
  output logic [`LU_LDBUF_ENTRIES-1:0] pend_o
);

  logic                        gnt_q;
  logic [`LU_REQ_ID_BITS-1:0]  gid_q;
  logic [`LU_INDEX_WIDTH-1:0]  idx_q;
  logic [`LU_ADDR_WIDTH-1:0]   addr_q [`LU_LDBUF_ENTRIES];
  logic [3:0]                  wait_q [`LU_LDBUF_ENTRIES];
  logic [15:0]                 rnd_q;
  logic                        found;
  int                          j;

  // aligned doubleword holding address a
  function automatic logic [`LU_XLEN-1:0] line_data(input logic [`LU_ADDR_WIDTH-1:0] a);
    logic [`LU_ADDR_WIDTH-1:0] b;
    logic [`LU_XLEN-1:0]       d;
    d = '0;
    for (int k = 0; k < `LU_XLEN / 8; k++) begin
      b = {a[`LU_ADDR_WIDTH-1:3], 3'b000} + k;
      d[8*k +: 8] = b[7:0] * 8'h9d + 8'h37;
    end
    return d;
  endfunction

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rid_o    = '0;
    rdata_o  = '0;
    pend_o   = '0;
    gnt_q    = 1'b0;
    for (int k = 0; k < `LU_LDBUF_ENTRIES; k++) begin
      wait_q[k] = '0;
    end
  end

  always @(posedge clk_i) begin
    rnd_q = rnd_i;
    if (!rst_ni) begin
      gnt_q  <= 1'b0;
      pend_o <= '0;
    end else begin
      // answered in the cycle that just ended
      if (rvalid_o) begin
        pend_o[rid_o] <= 1'b0;
      end
      for (int k = 0; k < `LU_LDBUF_ENTRIES; k++) begin
        if (wait_q[k] != 0) begin
          wait_q[k] <= wait_q[k] - 4'd1;
        end
      end
      // tag completes the request granted one cycle earlier
      // a kill in the tag cycle drops it
      if (gnt_q && tag_valid_i && !kill_i) begin
        pend_o[gid_q] <= 1'b1;
        addr_q[gid_q] <= {tag_i, idx_q};
        wait_q[gid_q] <= rnd_q[3:0];
      end
      gnt_q <= req_i & gnt_o;
      if (req_i && gnt_o) begin
        gid_q <= id_i;
        idx_q <= index_i;
      end
    end
    #10;
    // grant three cycles out of four
    gnt_o    = rst_ni & (rnd_q[5:4] != 2'b00);
    rvalid_o = 1'b0;
    found    = 1'b0;
    if (rst_ni && !hold_rsp_i && rnd_q[6]) begin
      // random starting slot, so answers come out of order
      for (int k = 0; k < `LU_LDBUF_ENTRIES; k++) begin
        j = (int'(rnd_q[8:7]) + k) % `LU_LDBUF_ENTRIES;
        if (!found && pend_o[j] && wait_q[j] == 0) begin
          found    = 1'b1;
          rvalid_o = 1'b1;
          rid_o    = j[`LU_REQ_ID_BITS-1:0];
          rdata_o  = line_data(addr_q[j]);
        end
      end
    end
  end

endmodule

// File: verification/tb_load_unit.sv
`timescale 1ns/100ps
`include "load_unit_params.svh"

module tb_load_unit;

  localparam int NUM_LOADS  = 400;
  // about thirty cycles per load covers gaps, stalls and drains
  localparam int MAX_CYCLES = NUM_LOADS * 30;

  logic                         clk;
  logic                         rst_n;
  logic                         flush;
  logic                         valid;
  logic [`LU_ADDR_WIDTH-1:0]    paddr;
  logic [7:0]                   be;
  load_unit_pkg::ld_op_t        op;
  logic [`LU_TRANS_ID_BITS-1:0] trans_id;
  logic                         pop_ld;
  logic                         res_valid;
  logic [`LU_TRANS_ID_BITS-1:0] res_tid;
  logic [`LU_XLEN-1:0]          result;
  logic                         data_req;
  logic                         data_gnt;
  logic [`LU_INDEX_WIDTH-1:0]   address_index;
  logic [`LU_TAG_WIDTH-1:0]     address_tag;
  logic                         tag_valid;
  logic                         kill_req;
  logic [7:0]                   data_be;
  load_unit_pkg::ld_size_t      data_size;
  logic [`LU_REQ_ID_BITS-1:0]   data_id;
  logic                         data_rvalid;
  logic [`LU_REQ_ID_BITS-1:0]   data_rid;
  logic [`LU_XLEN-1:0]          data_rdata;
  logic                         hold_rsp;
  logic [15:0]                  rnd;
  logic [`LU_LDBUF_ENTRIES-1:0] pend;

  // ------------------------------
  // scoreboard state
  // ------------------------------
  logic [31:0]                  lfsr_q = 32'h2d34ebe9;
  logic [(1<<`LU_TRANS_ID_BITS)-1:0] exp_valid = '0;
  logic [`LU_XLEN-1:0]          exp_result [1<<`LU_TRANS_ID_BITS];
  logic                         gnt_q;
  logic                         flush_q;
  logic [`LU_REQ_ID_BITS-1:0]   gid_q;
  logic [`LU_TAG_WIDTH-1:0]     tag_exp_q;
  int                           n_accepted = 0;
  int                           n_retired = 0;
  int                           n_flushed = 0;
  int                           cycle_cnt = 0;

  load_unit u_load_unit (
    .clk_i (clk), .rst_ni (rst_n), .flush_i (flush), .valid_i (valid),
    .paddr_i (paddr), .be_i (be), .op_i (op), .trans_id_i (trans_id),
    .pop_ld_o (pop_ld), .valid_o (res_valid), .trans_id_o (res_tid), .result_o (result),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .address_index_o (address_index),
    .address_tag_o (address_tag), .tag_valid_o (tag_valid), .kill_req_o (kill_req),
    .data_be_o (data_be), .data_size_o (data_size), .data_id_o (data_id),
    .data_rvalid_i (data_rvalid), .data_rid_i (data_rid), .data_rdata_i (data_rdata)
  );

  tb_dcache_model u_dcache_model (
    .clk_i (clk), .rst_ni (rst_n), .hold_rsp_i (hold_rsp), .rnd_i (rnd),
    .req_i (data_req), .index_i (address_index), .id_i (data_id),
    .tag_valid_i (tag_valid), .kill_i (kill_req), .tag_i (address_tag), .gnt_o (data_gnt),
    .rvalid_o (data_rvalid), .rid_o (data_rid), .rdata_o (data_rdata), .pend_o (pend)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h80200003 : 32'h0);
    end
    return r;
  endfunction

  function automatic int op_bytes(input load_unit_pkg::ld_op_t o);
    case (o)
      load_unit_pkg::LD:                     return 8;
      load_unit_pkg::LW, load_unit_pkg::LWU: return 4;
      load_unit_pkg::LH, load_unit_pkg::LHU: return 2;
      default:                               return 1;
    endcase
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  // memory byte at a is a * 9d + 37
  // the field sits little endian at a
  function automatic logic [`LU_XLEN-1:0] expected_load(input load_unit_pkg::ld_op_t o,
                                                        input logic [`LU_ADDR_WIDTH-1:0] a);
    logic [`LU_ADDR_WIDTH-1:0] b;
    logic [`LU_XLEN-1:0]       v;
    int                        nb;
    nb = op_bytes(o);
    v  = '0;
    for (int k = 0; k < nb; k++) begin
      b           = a + k;
      v[8*k +: 8] = b[7:0] * 8'h9d + 8'h37;
    end
    // signed loads copy the top bit of the field upward
    if ((o == load_unit_pkg::LW || o == load_unit_pkg::LH || o == load_unit_pkg::LB)
        && v[8*nb-1]) begin
      v = v | ~((64'd1 << (8 * nb)) - 64'd1);
    end
    return v;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------
  // random op, naturally aligned address, trans id not in flight
  task automatic start_load();
    logic [`LU_TRANS_ID_BITS-1:0] t;
    int                           nb;
    op    = load_unit_pkg::ld_op_t'(take_bits(3) % 7);
    nb    = op_bytes(op);
    paddr = take_bits(32) & ~32'(nb - 1);
    be    = 8'((1 << nb) - 1) << paddr[2:0];
    t     = take_bits(`LU_TRANS_ID_BITS);
    while (exp_valid[t]) begin
      t = t + 1'b1;
    end
    trans_id = t;
    valid    = 1'b1;
  endtask

  // returns 10 ns after the accepting edge, or after limit edges
  task automatic wait_accept(input int limit, input logic req_low, output logic got);
    got = 1'b0;
    for (int c = 0; c < limit && !got; c++) begin
      @(posedge clk);
      got = pop_ld;
      if (req_low) begin
        check_value("data_req_o", data_req, 1'b0);
      end
      #10;
      flush = 1'b0;
    end
    if (got) begin
      valid = 1'b0;
    end
  endtask

  // until nothing is left in the DUT or in the cache model
  task automatic drain();
    while (pend != 0 || exp_valid != 0 || tag_valid || data_req) begin
      @(posedge clk);
      #10;
    end
  endtask

  // fill every slot while responses are held so one more load has to wait
  task automatic fill_buffer();
    logic got;
    drain();
    hold_rsp = 1'b1;
    for (int k = 0; k < `LU_LDBUF_ENTRIES; k++) begin
      start_load();
      wait_accept(200, 1'b0, got);
      if (!got) begin
        fail_run("a load was not accepted while the buffer had free slots");
      end
    end
    start_load();
    wait_accept(40, 1'b1, got);
    if (got) begin
      fail_run("a load was accepted while the load buffer was full");
    end
    hold_rsp = 1'b0;
    wait_accept(200, 1'b0, got);
    if (!got) begin
      fail_run("the held load was not accepted after responses resumed");
    end
  endtask

  always @(posedge clk) begin
    #10;
    rnd = 16'(take_bits(16));
  end

  // ------------------------------
  // checker
  // ------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      gnt_q   = 1'b0;
      flush_q = 1'b0;
    end else begin
      if (res_valid) begin
        if (!exp_valid[res_tid]) begin
          fail_run("valid_o came for a load that is not outstanding");
        end
        check_value("result_o", result, exp_result[res_tid]);
        exp_valid[res_tid] = 1'b0;
        n_retired++;
      end
      // tag one cycle after a grant, and in the kill cycle
      check_value("tag_valid_o", tag_valid, gnt_q | flush_q);
      check_value("kill_req_o", kill_req, flush_q);
      if (gnt_q) begin
        check_value("address_tag_o", address_tag, tag_exp_q);
      end
      // request fields belong to the load held on the issue side
      if (data_req) begin
        check_value("address_index_o", address_index, paddr[`LU_INDEX_WIDTH-1:0]);
        check_value("data_be_o", data_be, be);
        check_value("data_size_o", data_size, $clog2(op_bytes(op)));
      end
      if (data_req && data_gnt) begin
        check_value("data_id_o in use", pend[data_id] | (gnt_q && data_id == gid_q), 1'b0);
      end
      if (pop_ld) begin
        exp_valid[trans_id]  = 1'b1;
        exp_result[trans_id] = expected_load(op, paddr);
        n_accepted++;
      end
      // loads accepted up to and in the flush cycle never return
      if (flush) begin
        n_flushed += $countones(exp_valid);
        exp_valid = '0;
      end
      gnt_q     = data_req & data_gnt;
      gid_q     = data_id;
      tag_exp_q = paddr[`LU_ADDR_WIDTH-1:`LU_INDEX_WIDTH];
      flush_q   = flush;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run("timeout, the loads did not complete within the cycle limit");
    end
  end

  initial begin
    int   n;
    logic got;
    rst_n    = 1'b0;
    flush    = 1'b0;
    valid    = 1'b0;
    paddr    = '0;
    be       = '0;
    op       = load_unit_pkg::LD;
    trans_id = '0;
    hold_rsp = 1'b0;
    rnd      = '0;
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;
    // quiet outputs with no stimulus
    repeat (20) begin
      @(posedge clk);
      check_value("data_req_o", data_req, 1'b0);
      check_value("pop_ld_o", pop_ld, 1'b0);
      check_value("valid_o", res_valid, 1'b0);
    end
    #10;
    for (n = 0; n < NUM_LOADS; n++) begin
      if (n == NUM_LOADS / 2) begin
        fill_buffer();
        n += `LU_LDBUF_ENTRIES;
      end else begin
        start_load();
        // flush with loads in flight and a request pending
        if (n % 40 == 39) begin
          flush = 1'b1;
        end
        wait_accept(200, 1'b0, got);
        if (!got) begin
          fail_run("a load was not accepted by the DUT");
        end
        repeat (take_bits(2)) begin
          @(posedge clk);
          #10;
        end
      end
    end
    drain();
    if (n_accepted == NUM_LOADS && n_retired + n_flushed == n_accepted) begin
      $display("Testbench passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d loads accepted, %0d retired, %0d flushed",
                         n_accepted, n_retired, n_flushed));
    end
  end

endmodule

// File: load_unit.f
+incdir+include
verilog/load_unit_pkg.sv
verilog/load_ctrl_fsm.sv
verilog/load_buffer.sv
verilog/load_align.sv
verilog/load_unit.sv
verification/tb_dcache_model.sv
verification/tb_load_unit.sv
